/* bench/mole_stim.txt */
// three hex words per command: op arg value
// op 1 press, 2 release, 3 start, 4 tick, 5 led, 6 nums, 7 read {err,addr}, 8 write,
// 9 hit, A miss, B model regs, C play time goal, D test done, 0 end
5 0 8001  6 0 FFFF  7 0 0000
D 1 0
3 0 0  5 0 FF01  6 0 3010  7 0 0001
1 16 0  2 16 0
1 1E 0  1 1E 0  2 1E 0
6 0 1210
1 1C 0  2 1C 0
6 0 1210  5 0 FF01
1 29 0  2 29 0
5 0 80FF
1 3D 0  2 3D 0
6 0 1207  7 0 0009
D 2 0
1 29 0  2 29 0  5 0 FF01
1 45 0  2 45 0  1 26 0  2 26 0
1 29 0  2 29 0
1 45 0  2 45 0  1 2E 0  2 2E 0
6 0 0305
C 3 5  6 0 0300  5 0 B003
4 0 0  6 0 0200  4 0 0  6 0 0100  B 0 0
4 0 0  6 0 D05E  5 0 FFFF  7 0 000B
4 0 0  5 0 0000  4 0 0  5 0 FFFF
4 0 0  5 0 0000  4 0 0  5 0 8001  6 0 FFFF
D 3 0
3 0 0  6 0 3010
1 29 0  2 29 0
1 45 0  2 45 0  1 1E 0  2 1E 0
6 0 3002
C 1E 2  6 0 3000
A 0 0  B 0 0  9 0 0  B 0 0  6 0 3001
4 0 0  B 0 0  A 0 0  9 0 0
6 0 FABC  7 0 000F
D 4 0
B 0 0  8 0 1234  7 12 0000  7 0 000F
4 0 0  4 0 0  4 0 0  4 0 0
5 0 8001  7 0 0000
D 5 0
0 0 0

/* flist.f */
+incdir+src
src/mole_pkg.sv
src/key_decode.sv
src/game_ctrl.sv
src/mole_lfsr.sv
src/panel_format.sv
src/apb_status.sv
src/mole_top.sv
bench/mole_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mole testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f flist.f --top-module mole_tb -o mole_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/mole_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF "Test completed successfully"; then
  exit 0
fi
exit 1

/* bench/mole_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mole_tb;

  localparam int STIM_WORDS = 300;
  localparam logic [8:0] SEED_MASK = 9'b1_0110_0000;

  logic        clk;
  logic        out_rst;
  logic        key_valid;
  logic [8:0]  key_code;
  logic        key_make;
  logic        start;
  logic        tick;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [15:0] led;
  logic [15:0] nums;

  logic [15:0] stim_mem [0:STIM_WORDS-1];
  int          pc;
  logic [3:0]  op;
  logic [15:0] arg;
  logic [15:0] val;
  logic        running;
  logic [31:0] rd;
  logic        er;
  integer      seed;
  int          errors;
  int          test_errors;
  int          checks;
  int          tests_done;
  logic [3:0]  cur_test;
  logic        timed_out;

  // reference game state from the rules
  logic        model_play;
  logic [7:0]  model_time;
  logic [7:0]  model_score;
  logic [7:0]  model_goal;
  logic [8:0]  model_mask;

  mole_top dut (
    .clk       (clk),
    .out_rst   (out_rst),
    .key_valid (key_valid),
    .key_code  (key_code),
    .key_make  (key_make),
    .start     (start),
    .tick      (tick),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .led       (led),
    .nums      (nums)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic string test_name(input logic [3:0] n);
    case (n)
      4'd1:    return "reset_idle";
      4'd2:    return "setup_entry";
      4'd3:    return "timeout_loss";
      4'd4:    return "hits_win";
      4'd5:    return "apb_regs";
      default: return "unknown";
    endcase
  endfunction

  // set 2 main row codes
  function automatic logic [8:0] digit_code(input logic [3:0] d);
    case (d)
      4'd1:    return 9'h016;
      4'd2:    return 9'h01E;
      4'd3:    return 9'h026;
      4'd4:    return 9'h025;
      4'd5:    return 9'h02E;
      4'd6:    return 9'h036;
      4'd7:    return 9'h03D;
      4'd8:    return 9'h03E;
      4'd9:    return 9'h046;
      default: return 9'h045;
    endcase
  endfunction

  function automatic logic [8:0] lfsr_step(input logic [8:0] m);
    logic [8:0] n;
    n[8] = m[0];
    n[7] = m[8];
    n[6] = m[7] ^ m[0];
    n[5] = m[6] ^ m[0];
    n[4] = m[5];
    n[3] = m[4] ^ m[0];
    n[2] = m[3];
    n[1] = m[2];
    n[0] = m[1];
    return n;
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic settle_pipeline();
    repeat (4) @(negedge clk);   // key to panel is 3 cycles
  endtask

  task automatic send_key(input logic [8:0] code, input logic make);
    @(negedge clk);
    key_valid = 1'b1;
    key_code  = code;
    key_make  = make;
    @(negedge clk);
    key_valid = 1'b0;
    key_make  = 1'b0;
    settle_pipeline();
  endtask

  task automatic pulse_control(input logic is_tick);
    @(negedge clk);
    if (is_tick)
      tick = 1'b1;
    else
      start = 1'b1;
    @(negedge clk);
    tick  = 1'b0;
    start = 1'b0;
    settle_pipeline();
  endtask

  task automatic end_model_play();
    model_play = 1'b0;
    model_mask = SEED_MASK;   // run low reloads the seed
  endtask

  task automatic expect_panel(input logic is_nums, input logic [15:0] exp);
    int n;
    logic [15:0] act;
    n = 0;
    act = is_nums ? nums : led;
    while (act !== exp && n < 8) begin
      @(negedge clk);
      act = is_nums ? nums : led;
      n++;
    end
    assert (act === exp) else begin
      $display("FAIL %s %s: expected %h, actual %h", test_name(cur_test),
               is_nums ? "nums" : "led", exp, act);
      note_error();
    end
    checks++;
  endtask

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    n = 0;
    while (pready !== 1'b1 && n < 16) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (pready !== 1'b1) begin
      $display("apb transfer timed out waiting for pready");
      timed_out = 1'b1;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_check(input string what, input logic [3:0] addr,
                           input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] data;
    logic        err;
    apb_access(1'b0, addr, 32'd0, data, err);
    assert (data === exp_data && err === exp_err) else begin
      $display("FAIL %s %s: expected %h err %b, actual %h err %b", test_name(cur_test),
               what, exp_data, exp_err, data, err);
      note_error();
    end
    checks++;
  endtask

  task automatic whack_lit_lamp();
    int         d;
    logic [3:0] pick;
    logic [3:0] lamp;
    pick = 4'd0;
    for (d = 9; d >= 1; d--) begin
      lamp = 4'(9 - d);
      if (model_mask[lamp])
        pick = 4'(d);   // lowest lit digit wins
    end
    assert (pick != 4'd0) else begin
      $display("%s: the model shows no lit lamp to hit", test_name(cur_test));
      note_error();
    end
    if (pick != 4'd0) begin
      send_key(digit_code(pick), 1'b1);
      send_key(digit_code(pick), 1'b0);
      lamp = 4'(9 - pick);
      model_mask[lamp] = 1'b0;
      model_score = model_score + 8'd1;
      if (model_score == model_goal)
        end_model_play();
    end
  endtask

  task automatic press_unlit_digit();
    int         tries;
    int         d;
    logic [3:0] pick;
    logic [3:0] lamp;
    pick = 4'd0;
    for (tries = 0; tries < 40; tries++) begin
      d = ($random(seed) & 32'h7fff_ffff) % 10;
      lamp = 4'(9 - d);
      if (d == 0 || !model_mask[lamp]) begin
        pick = 4'(d);
        break;
      end
    end
    send_key(digit_code(pick), 1'b1);
    send_key(digit_code(pick), 1'b0);
  endtask

  initial begin
    seed        = 98;
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    tests_done  = 0;
    cur_test    = 4'd1;
    timed_out   = 1'b0;
    model_play  = 1'b0;
    model_time  = 8'd0;
    model_score = 8'd0;
    model_goal  = 8'd0;
    model_mask  = SEED_MASK;
    out_rst     = 1'b1;
    key_valid   = 1'b0;
    key_code    = 9'd0;
    key_make    = 1'b0;
    start       = 1'b0;
    tick        = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = 4'd0;
    pwdata      = 32'd0;
    $readmemh("bench/mole_stim.txt", stim_mem);
    repeat (3) @(posedge clk);
    @(negedge clk);
    assert (led === 16'h0000 && nums === 16'hFFFF) else begin
      $display("FAIL %s reset: expected led 0000 nums ffff, actual led %h nums %h",
               test_name(cur_test), led, nums);
      note_error();
    end
    checks++;
    out_rst = 1'b0;

    pc      = 0;
    running = 1'b1;
    while (running && pc <= STIM_WORDS - 3) begin
      op  = stim_mem[pc][3:0];
      arg = stim_mem[pc+1];
      val = stim_mem[pc+2];
      pc  = pc + 3;
      case (op)
        4'h0: running = 1'b0;
        4'h1: send_key(arg[8:0], 1'b1);
        4'h2: send_key(arg[8:0], 1'b0);
        4'h3: pulse_control(1'b0);
        4'h4: begin
          pulse_control(1'b1);
          if (model_play) begin
            model_time = model_time - 8'd1;
            model_mask = lfsr_step(model_mask);
            if (model_time == 8'd0)
              end_model_play();
          end
        end
        4'h5: expect_panel(1'b0, val);
        4'h6: expect_panel(1'b1, val);
        4'h7: apb_check("apb read", arg[3:0], {16'd0, val}, arg[4]);
        4'h8: begin
          apb_access(1'b1, arg[3:0], {16'd0, val}, rd, er);
          assert (er === 1'b1) else begin
            $display("FAIL %s apb write: expected pslverr 1, actual %b", test_name(cur_test), er);
            note_error();
          end
          checks++;
        end
        4'h9: whack_lit_lamp();
        4'hA: press_unlit_digit();
        4'hB: begin
          apb_check("score", 4'h4, {24'd0, model_score}, 1'b0);
          apb_check("time_left", 4'h8, {24'd0, model_time}, 1'b0);
          apb_check("mask", 4'hC, {23'd0, model_mask}, 1'b0);
        end
        4'hC: begin
          model_time  = arg[7:0];
          model_goal  = val[7:0];
          model_score = 8'd0;
          model_mask  = SEED_MASK;
          model_play  = 1'b1;
          pulse_control(1'b0);
        end
        4'hD: begin
          $display("test %0d %s: %s, %0d errors", arg[3:0], test_name(arg[3:0]),
                   test_errors == 0 ? "passed" : "had errors", test_errors);
          tests_done++;
          test_errors = 0;
          cur_test    = arg[3:0] + 4'd1;
        end
        default: begin
          $display("unknown stimulus command %h at word %0d", op, pc - 3);
          errors++;
          running = 1'b0;
        end
      endcase
      if (timed_out)
        running = 1'b0;
    end

    if (tests_done != 5)
      $display("only %0d of 5 tests ran", tests_done);
    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
    if (errors == 0 && !timed_out && tests_done == 5)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* src/mole_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mole_top (
  input  wire                       clk,
  input  wire                       out_rst,
  input  wire                       key_valid,
  input  wire mole_pkg::scan_code_t key_code,
  input  wire                       key_make,
  input  wire                       start,
  input  wire                       tick,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire [3:0]                 paddr,
  input  wire [31:0]                pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic [15:0]               led,
  output logic [15:0]               nums
);
  import mole_pkg::*;

  key_event_t   key_ev;
  hit_t         hit;
  logic         run;
  ctrl_status_t status;
  mole_mask_t   mask;

  key_decode u_key_decode (
    .clk       (clk),
    .out_rst   (out_rst),
    .key_valid (key_valid),
    .key_code  (key_code),
    .key_make  (key_make),
    .key_ev    (key_ev)
  );

  game_ctrl u_game_ctrl (
    .clk     (clk),
    .out_rst (out_rst),
    .key_ev  (key_ev),
    .start   (start),
    .tick    (tick),
    .mask    (mask),
    .hit     (hit),
    .run     (run),
    .status  (status)
  );

  mole_lfsr u_mole_lfsr (
    .clk     (clk),
    .out_rst (out_rst),
    .run     (run),
    .tick    (tick),
    .hit     (hit),
    .mask    (mask)
  );

  panel_format u_panel_format (
    .clk     (clk),
    .out_rst (out_rst),
    .status  (status),
    .mask    (mask),
    .led     (led),
    .nums    (nums)
  );

  apb_status u_apb_status (
    .clk     (clk),
    .out_rst (out_rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .status  (status),
    .mask    (mask)
  );

endmodule

`default_nettype wire

/* src/apb_status.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mole_consts.svh"

module apb_status (
  input  wire                        clk,
  input  wire                        out_rst,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [3:0]                  paddr,
  input  wire [31:0]                 pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  wire mole_pkg::ctrl_status_t status,
  input  wire mole_pkg::mole_mask_t  mask
);
  import mole_pkg::*;

  logic mapped;

  assign pready = 1'b1;   // no wait states

  always_comb begin
    mapped = 1'b1;
    case (paddr)
      `ADDR_STATUS: prdata = {28'd0, status.field_goal, status.win, status.state};
      `ADDR_SCORE:  prdata = {24'd0, status.score};
      `ADDR_TIME:   prdata = {24'd0, status.time_left};
      `ADDR_MASK:   prdata = {23'd0, mask};
      default: begin
        prdata = '0;
        mapped = 1'b0;
      end
    endcase
  end

  // decided in setup phase, shown during access
  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst)
      pslverr <= 1'b0;
    else
      pslverr <= psel && !penable && (pwrite || !mapped);
  end

endmodule

`default_nettype wire

/* src/panel_format.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mole_consts.svh"

module panel_format (
  input  wire                        clk,
  input  wire                        out_rst,
  input  wire mole_pkg::ctrl_status_t status,
  input  wire mole_pkg::mole_mask_t  mask,
  output logic [15:0]                led,
  output logic [15:0]                nums
);
  import mole_pkg::*;

  logic [15:0] led_next;
  logic [15:0] nums_next;

  // counts stay below 100 so two digits do
  function automatic bcd2_t to_bcd(input count_t v);
    return {4'((v / 8'd10) % 8'd10), 4'(v % 8'd10)};
  endfunction

  always_comb begin
    case (status.state)
      st_setup: begin
        led_next  = status.field_goal ? 16'h80FF : 16'hFF01;
        nums_next = {status.time_bcd, status.goal_bcd};
      end
      st_play: begin
        led_next  = {mask, 7'b000_0011};
        nums_next = {to_bcd(status.time_left), to_bcd(status.score)};
      end
      st_final: begin
        led_next  = status.final_phase ? 16'h0000 : 16'hFFFF;
        nums_next = status.win ? `NUMS_WIN : `NUMS_LOSE;
      end
      default: begin   // idle
        led_next  = 16'h8001;
        nums_next = `NUMS_BLANK;
      end
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      led  <= '0;
      nums <= `NUMS_BLANK;
    end else begin
      led  <= led_next;
      nums <= nums_next;
    end
  end

endmodule

`default_nettype wire

/* src/mole_lfsr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mole_consts.svh"

module mole_lfsr (
  input  wire                    clk,
  input  wire                    out_rst,
  input  wire                    run,
  input  wire                    tick,
  input  wire mole_pkg::hit_t    hit,
  output mole_pkg::mole_mask_t   mask
);
  import mole_pkg::*;

  mole_mask_t mask_next;

  always_comb begin
    mask_next = mask;
    if (tick) begin
      // rotate right with taps at 6, 5 and 3
      mask_next = {mask[0], mask[8], mask[7] ^ mask[0], mask[6] ^ mask[0], mask[5],
                   mask[4] ^ mask[0], mask[3], mask[2], mask[1]};
    end
    if (hit.valid)
      mask_next[hit.idx] = 1'b0;   // whacked lamp goes dark
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst)
      mask <= `MOLE_SEED;
    else if (!run)
      mask <= `MOLE_SEED;
    else
      mask <= mask_next;
  end

endmodule

`default_nettype wire

/* src/game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mole_consts.svh"

module game_ctrl (
  input  wire                    clk,
  input  wire                    out_rst,
  input  wire mole_pkg::key_event_t key_ev,
  input  wire                    start,
  input  wire                    tick,
  input  wire mole_pkg::mole_mask_t mask,
  output mole_pkg::hit_t         hit,
  output logic                   run,
  output mole_pkg::ctrl_status_t status
);
  import mole_pkg::*;

  game_state_e state;
  logic        field_goal;
  logic        win;
  logic        final_phase;
  logic [2:0]  final_cnt;
  count_t      time_left;
  count_t      score;
  count_t      goal;
  bcd2_t       time_bcd;
  bcd2_t       goal_bcd;
  logic        play_done;
  logic [3:0]  hit_idx;

  function automatic count_t bcd_to_bin(input bcd2_t b);
    return count_t'(b[7:4]) * 8'd10 + count_t'(b[3:0]);
  endfunction

  assign run       = (state == st_play);
  assign play_done = (time_left == '0) || (score == goal);
  assign hit_idx   = 4'd9 - key_ev.digit;   // key 1 is the top lamp

  always_comb begin
    hit.idx   = hit_idx;
    hit.valid = run && !play_done && key_ev.valid && key_ev.is_digit &&
                (key_ev.digit != 4'd0) && (key_ev.digit <= 4'd9) && mask[hit_idx];
  end

  always_comb begin
    status.state       = state;
    status.field_goal  = field_goal;
    status.win         = win;
    status.final_phase = final_phase;
    status.time_left   = time_left;
    status.score       = score;
    status.time_bcd    = time_bcd;
    status.goal_bcd    = goal_bcd;
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      state       <= st_idle;
      field_goal  <= 1'b0;
      win         <= 1'b0;
      final_phase <= 1'b0;
      final_cnt   <= '0;
      time_left   <= '0;
      score       <= '0;
      goal        <= '0;
      time_bcd    <= `DEFAULT_TIME_BCD;
      goal_bcd    <= `DEFAULT_GOAL_BCD;
    end else begin
      case (state)
        st_idle: begin
          time_bcd    <= `DEFAULT_TIME_BCD;
          goal_bcd    <= `DEFAULT_GOAL_BCD;
          score       <= '0;
          field_goal  <= 1'b0;
          win         <= 1'b0;
          final_phase <= 1'b0;
          if (start) state <= st_setup;
        end
        st_setup: begin
          if (start) begin
            time_left <= bcd_to_bin(time_bcd);
            goal      <= bcd_to_bin(goal_bcd);
            score     <= '0;
            state     <= st_play;
          end else if (key_ev.valid && key_ev.is_digit) begin
            if (field_goal) goal_bcd <= {goal_bcd[3:0], key_ev.digit};
            else time_bcd <= {time_bcd[3:0], key_ev.digit};
          end else if (key_ev.valid && key_ev.is_space) begin
            field_goal <= !field_goal;
          end
        end
        st_play: begin
          if (play_done) begin
            state       <= st_final;
            win         <= (score == goal);
            final_cnt   <= '0;
            final_phase <= 1'b0;
          end else begin
            if (tick) time_left <= time_left - 8'd1;
            if (hit.valid) score <= score + 8'd1;
          end
        end
        st_final: begin
          if (tick) begin
            final_phase <= !final_phase;
            if (final_cnt == `FINAL_TICKS - 3'd1) state <= st_idle;
            else final_cnt <= final_cnt + 3'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/key_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mole_consts.svh"

module key_decode (
  input  wire                  clk,
  input  wire                  out_rst,
  input  wire                  key_valid,
  input  wire mole_pkg::scan_code_t key_code,
  input  wire                  key_make,
  output mole_pkg::key_event_t key_ev
);
  import mole_pkg::*;

  scan_code_t held_code;   // 0 when nothing is held
  key_event_t ev_next;
  logic       new_press;

  assign new_press = key_valid && key_make && (key_code != held_code);

  // main row and keypad both give digits
  always_comb begin
    ev_next          = '0;
    ev_next.valid    = new_press;
    ev_next.is_digit = 1'b1;
    case (key_code)
      9'h045, 9'h070: ev_next.digit = 4'd0;
      9'h016, 9'h069: ev_next.digit = 4'd1;
      9'h01E, 9'h072: ev_next.digit = 4'd2;
      9'h026, 9'h07A: ev_next.digit = 4'd3;
      9'h025, 9'h06B: ev_next.digit = 4'd4;
      9'h02E, 9'h073: ev_next.digit = 4'd5;
      9'h036, 9'h074: ev_next.digit = 4'd6;
      9'h03D, 9'h06C: ev_next.digit = 4'd7;
      9'h03E, 9'h075: ev_next.digit = 4'd8;
      9'h046, 9'h07D: ev_next.digit = 4'd9;
      default:        ev_next.is_digit = 1'b0;
    endcase
    ev_next.is_space = (key_code == `KEY_SPACE);
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      held_code <= '0;
      key_ev    <= '0;
    end else begin
      key_ev <= ev_next;
      if (new_press)
        held_code <= key_code;
      else if (key_valid && !key_make)
        held_code <= '0;   // any break releases
    end
  end

endmodule

`default_nettype wire

/* src/mole_pkg.sv */
`default_nettype none

package mole_pkg;

  typedef logic [8:0] scan_code_t;   // bit 8 flags an extended key
  typedef logic [7:0] bcd2_t;
  typedef logic [7:0] count_t;
  typedef logic [8:0] mole_mask_t;

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_play,
    st_final
  } game_state_e;

  typedef struct packed {
    logic       valid;
    logic       is_digit;
    logic       is_space;
    logic [3:0] digit;
  } key_event_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] idx;   // lamp 0..8
  } hit_t;

  typedef struct packed {
    game_state_e state;
    logic        field_goal;
    logic        win;
    logic        final_phase;   // flash polarity
    count_t      time_left;
    count_t      score;
    bcd2_t       time_bcd;
    bcd2_t       goal_bcd;
  } ctrl_status_t;

endpackage

`default_nettype wire

/* src/mole_consts.svh */
`ifndef MOLE_CONSTS_SVH
`define MOLE_CONSTS_SVH

// space bar toggles the setup field
`define KEY_SPACE 9'h029

// setup defaults
`define DEFAULT_TIME_BCD 8'h30
`define DEFAULT_GOAL_BCD 8'h10

`define MOLE_SEED 9'b1_0110_0000

// ticks spent flashing the result
`define FINAL_TICKS 3'd4

`define NUMS_WIN   16'hFABC
`define NUMS_LOSE  16'hD05E
`define NUMS_BLANK 16'hFFFF

`define ADDR_STATUS 4'h0
`define ADDR_SCORE  4'h4
`define ADDR_TIME   4'h8
`define ADDR_MASK   4'hC

`endif
